/* files.f */
src/rv32CorePkg.sv
src/pipeBus.sv
src/instrQueue.sv
src/decodeStage.sv
src/regFile.sv
src/executeStage.sv
src/memStage.sv
src/rv32Core.sv
tests/coreTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the core testbench, the log decides the result
rm -f sim.log
verilator --binary -f files.f --top-module coreTb -o coreSim || exit 1
./obj_dir/coreSim | tee sim.log
test -s sim.log || exit 1
grep -q "tests failed" sim.log && exit 1 || exit 0

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic reset,
	input logic headValid_i,
	input logic [rv32CorePkg::XLEN-1:0] headInstr_i,
	output logic pop_o,
	input logic [rv32CorePkg::REG_NUM_W-1:0] exRd_i,
	input logic exIsLoad_i,
	input logic exValid_i,
	output logic [rv32CorePkg::REG_NUM_W-1:0] rs1Num_o,
	output logic [rv32CorePkg::REG_NUM_W-1:0] rs2Num_o,
	input logic [rv32CorePkg::XLEN-1:0] rs1Data_i,
	input logic [rv32CorePkg::XLEN-1:0] rs2Data_i,
	exBus_if.dec ex
);
	import rv32CorePkg::*;

	decoded_t dec;
	logic usesRs1;
	logic usesRs2;
	logic hazard;
	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = headInstr_i[6:0];
	assign funct3 = headInstr_i[14:12];
	assign rs1Num_o = headInstr_i[19:15];
	assign rs2Num_o = headInstr_i[24:20];

	always_comb
	begin
		dec = '0;
		dec.rs1 = rs1Num_o;
		dec.rs2 = rs2Num_o;
		dec.aluOp = ADD;
		dec.memOp = NONE;
		usesRs1 = 1'b1;
		usesRs2 = 1'b0;
		case (opcode)
			OP_REG:
			begin
				dec.writesRd = 1'b1;
				usesRs2 = 1'b1;
			end
			OP_IMM, OP_LOAD:
			begin
				dec.writesRd = 1'b1;
				dec.useImm = 1'b1;
				dec.imm = {{20{headInstr_i[31]}}, headInstr_i[31:20]};
				if (opcode == OP_LOAD)
					dec.memOp = LOAD;
			end
			OP_STORE:
			begin
				dec.useImm = 1'b1;
				dec.imm = {{20{headInstr_i[31]}}, headInstr_i[31:25], headInstr_i[11:7]};
				dec.memOp = STORE;
				usesRs2 = 1'b1; // store data
			end
			OP_LUI:
			begin
				dec.writesRd = 1'b1;
				dec.useImm = 1'b1;
				dec.imm = {headInstr_i[31:12], 12'b0};
				dec.aluOp = PASS_Y;
				usesRs1 = 1'b0;
			end
			default: usesRs1 = 1'b0; // unknown opcode retires as a no-op
		endcase
		if (opcode == OP_REG || opcode == OP_IMM)
		begin
			case (funct3)
				3'd0: dec.aluOp = (opcode == OP_REG && headInstr_i[30]) ? SUB : ADD;
				3'd1: dec.aluOp = SLL;
				3'd2: dec.aluOp = SLT;
				3'd3: dec.aluOp = SLTU;
				3'd4: dec.aluOp = XOR;
				3'd5: dec.aluOp = (opcode == OP_REG ? headInstr_i[30] : dec.imm[10]) ? SRA : SRL;
				3'd6: dec.aluOp = OR;
				default: dec.aluOp = AND;
			endcase
		end
		dec.rd = dec.writesRd ? headInstr_i[11:7] : '0;
	end

	// loaded value is not ready for a consumer directly behind the load
	assign hazard = exValid_i && exIsLoad_i && exRd_i != '0 &&
		((usesRs1 && rs1Num_o == exRd_i) || (usesRs2 && rs2Num_o == exRd_i));
	assign pop_o = headValid_i && !hazard;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ex.decoded <= '0;
			ex.rs1Num <= '0;
			ex.rs2Num <= '0;
		end
		else
		begin
			ex.decoded <= dec;
			ex.decoded.valid <= pop_o; // bubble on stall or empty queue
			ex.rs1Num <= usesRs1 ? rs1Num_o : '0;
			ex.rs2Num <= usesRs2 ? rs2Num_o : '0;
		end
	end

	always_ff @(posedge clk)
	begin
		ex.rs1Data <= rs1Data_i;
		ex.rs2Data <= rs2Data_i;
	end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic reset,
	exBus_if.ex ex,
	wbBus_if.fwd wb,
	output logic [rv32CorePkg::REG_NUM_W-1:0] exRd_o,
	output logic exIsLoad_o,
	output logic exValid_o,
	output logic [rv32CorePkg::XLEN-1:0] aluResult_o,
	output logic [rv32CorePkg::XLEN-1:0] storeData_o,
	output logic [rv32CorePkg::REG_NUM_W-1:0] memRd_o,
	output rv32CorePkg::memOp_t memOp_o,
	output logic memWritesRd_o,
	output logic memValid_o
);
	import rv32CorePkg::*;

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] fwdB;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluOut;
	logic memFwdOk;

	assign exRd_o = ex.decoded.rd;
	assign exIsLoad_o = (ex.decoded.memOp == LOAD);
	assign exValid_o = ex.decoded.valid;

	// load results never sit here when needed, the stall sees to that
	assign memFwdOk = memValid_o && memWritesRd_o && memOp_o != LOAD;

	function automatic logic [XLEN-1:0] forward(input logic [REG_NUM_W-1:0] num,
		input logic [XLEN-1:0] regVal);
		if (num == '0)
			return regVal;
		if (memFwdOk && memRd_o == num)
			return aluResult_o;
		if (wb.wbValid && wb.wbWrite && wb.wbRd == num)
			return wb.wbData;
		return regVal;
	endfunction

	always_comb
	begin
		opA = forward(ex.rs1Num, ex.rs1Data);
		fwdB = forward(ex.rs2Num, ex.rs2Data);
		opB = ex.decoded.useImm ? ex.decoded.imm : fwdB;
		case (ex.decoded.aluOp)
			ADD: aluOut = opA + opB;
			SUB: aluOut = opA - opB;
			SLL: aluOut = opA << opB[4:0];
			SLT: aluOut = XLEN'($signed(opA) < $signed(opB));
			SLTU: aluOut = XLEN'(opA < opB);
			XOR: aluOut = opA ^ opB;
			SRL: aluOut = opA >> opB[4:0];
			SRA: aluOut = $signed(opA) >>> opB[4:0];
			OR: aluOut = opA | opB;
			AND: aluOut = opA & opB;
			default: aluOut = opB; // PASS_Y
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			memValid_o <= 1'b0;
			memRd_o <= '0;
			memOp_o <= NONE;
			memWritesRd_o <= 1'b0;
		end
		else
		begin
			memValid_o <= ex.decoded.valid;
			memRd_o <= ex.decoded.rd;
			memOp_o <= ex.decoded.memOp;
			memWritesRd_o <= ex.decoded.writesRd && ex.decoded.rd != '0;
		end
	end

	always_ff @(posedge clk)
	begin
		aluResult_o <= aluOut;
		storeData_o <= fwdB;
	end

endmodule

/* src/instrQueue.sv */
`timescale 1ns/1ps

module instrQueue (
	input logic clk,
	input logic reset,
	input logic pushValid_i,
	input logic [rv32CorePkg::XLEN-1:0] pushInstr_i,
	input logic pop_i,
	output logic headValid_o,
	output logic [rv32CorePkg::XLEN-1:0] headInstr_o,
	output logic creditReturn_o
);
	import rv32CorePkg::*;

	logic [XLEN-1:0] buffer [IQ_DEPTH];
	logic [IQ_PTR_W-1:0] wrPtr;
	logic [IQ_PTR_W-1:0] rdPtr;
	logic [CREDIT_W-1:0] count;
	logic doPop;

	assign headValid_o = (count != '0);
	assign headInstr_o = buffer[rdPtr];
	assign doPop = pop_i && headValid_o;
	assign creditReturn_o = doPop; // one credit back per word taken

	// sender credits keep this from ever overflowing
	always_ff @(posedge clk)
	begin
		if (pushValid_i)
			buffer[wrPtr] <= pushInstr_i;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (pushValid_i)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + CREDIT_W'(pushValid_i) - CREDIT_W'(doPop);
		end
	end

endmodule

/* src/memStage.sv */
`timescale 1ns/1ps

module memStage (
	input logic clk,
	input logic reset,
	input logic [rv32CorePkg::XLEN-1:0] aluResult_i,
	input logic [rv32CorePkg::XLEN-1:0] storeData_i,
	input logic [rv32CorePkg::REG_NUM_W-1:0] rd_i,
	input rv32CorePkg::memOp_t memOp_i,
	input logic writesRd_i,
	input logic valid_i,
	wbBus_if.src wb,
	output logic retireValid_o,
	output logic [rv32CorePkg::REG_NUM_W-1:0] retireRd_o,
	output logic [rv32CorePkg::XLEN-1:0] retireData_o
);
	import rv32CorePkg::*;

	logic [XLEN-1:0] ram [DMEM_WORDS];
	logic [DMEM_AW-1:0] wordAddr;
	logic [XLEN-1:0] loadData;
	logic [XLEN-1:0] result;
	logic writes;

	assign wordAddr = aluResult_i[DMEM_AW+1:2];
	assign loadData = ram[wordAddr]; // read before the edge that may write
	assign writes = writesRd_i && rd_i != '0;
	assign result = !writes ? '0 : (memOp_i == LOAD) ? loadData : aluResult_i;

	always_ff @(posedge clk)
	begin
		if (valid_i && memOp_i == STORE)
			ram[wordAddr] <= storeData_i;
		retireRd_o <= rd_i;
		retireData_o <= result;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			retireValid_o <= 1'b0;
			wb.wbWrite <= 1'b0;
		end
		else
		begin
			retireValid_o <= valid_i;
			wb.wbWrite <= writes;
		end
	end

	assign wb.wbValid = retireValid_o;
	assign wb.wbRd = retireRd_o;
	assign wb.wbData = retireData_o;

endmodule

/* src/pipeBus.sv */
`timescale 1ns/1ps

// decode register contents as seen by execute
interface exBus_if;
	import rv32CorePkg::*;

	decoded_t decoded;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic [REG_NUM_W-1:0] rs1Num; // zero when operand unused
	logic [REG_NUM_W-1:0] rs2Num;

	modport dec (output decoded, rs1Data, rs2Data, rs1Num, rs2Num);
	modport ex (input decoded, rs1Data, rs2Data, rs1Num, rs2Num);
endinterface

interface wbBus_if;
	import rv32CorePkg::*;

	logic wbValid;
	logic [REG_NUM_W-1:0] wbRd;
	logic [XLEN-1:0] wbData;
	logic wbWrite; // rd is a real destination

	modport src (output wbValid, wbRd, wbData, wbWrite);
	modport regs (input wbValid, wbRd, wbData, wbWrite);
	modport fwd (input wbValid, wbRd, wbData, wbWrite);
endinterface

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	input logic [rv32CorePkg::REG_NUM_W-1:0] rs1Num_i,
	input logic [rv32CorePkg::REG_NUM_W-1:0] rs2Num_i,
	output logic [rv32CorePkg::XLEN-1:0] rs1Data_o,
	output logic [rv32CorePkg::XLEN-1:0] rs2Data_o,
	wbBus_if.regs wb
);
	import rv32CorePkg::*;

	logic [XLEN-1:0] regs [2**REG_NUM_W];
	logic wrEn;

	assign wrEn = wb.wbValid && wb.wbWrite && wb.wbRd != '0; // x0 never written

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**REG_NUM_W; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
			regs[wb.wbRd] <= wb.wbData;
	end

	// same-cycle write shows through to the reader
	assign rs1Data_o = (rs1Num_i == '0) ? '0 :
		(wrEn && wb.wbRd == rs1Num_i) ? wb.wbData : regs[rs1Num_i];
	assign rs2Data_o = (rs2Num_i == '0) ? '0 :
		(wrEn && wb.wbRd == rs2Num_i) ? wb.wbData : regs[rs2Num_i];

endmodule

/* src/rv32Core.sv */
`timescale 1ns/1ps

module rv32Core (
	input logic clk,
	input logic reset,
	input logic instrValid_i,
	input logic [rv32CorePkg::XLEN-1:0] instr_i,
	output logic creditReturn_o,
	output logic retireValid_o,
	output logic [rv32CorePkg::REG_NUM_W-1:0] retireRd_o,
	output logic [rv32CorePkg::XLEN-1:0] retireData_o
);
	import rv32CorePkg::*;

	logic headValid;
	logic [XLEN-1:0] headInstr;
	logic pop;
	logic [REG_NUM_W-1:0] rs1Num;
	logic [REG_NUM_W-1:0] rs2Num;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic [REG_NUM_W-1:0] exRd;
	logic exIsLoad;
	logic exValid;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] storeData;
	logic [REG_NUM_W-1:0] memRd;
	memOp_t memOp;
	logic memWritesRd;
	logic memValid;

	exBus_if exBus ();
	wbBus_if wbBus ();

	instrQueue instrQueue_i (
		.clk(clk), .reset(reset),
		.pushValid_i(instrValid_i), .pushInstr_i(instr_i), .pop_i(pop),
		.headValid_o(headValid), .headInstr_o(headInstr), .creditReturn_o(creditReturn_o)
	);

	decodeStage decodeStage_i (
		.clk(clk), .reset(reset),
		.headValid_i(headValid), .headInstr_i(headInstr), .pop_o(pop),
		.exRd_i(exRd), .exIsLoad_i(exIsLoad), .exValid_i(exValid),
		.rs1Num_o(rs1Num), .rs2Num_o(rs2Num), .rs1Data_i(rs1Data), .rs2Data_i(rs2Data),
		.ex(exBus.dec)
	);

	regFile regFile_i (
		.clk(clk), .reset(reset),
		.rs1Num_i(rs1Num), .rs2Num_i(rs2Num), .rs1Data_o(rs1Data), .rs2Data_o(rs2Data),
		.wb(wbBus.regs)
	);

	executeStage executeStage_i (
		.clk(clk), .reset(reset), .ex(exBus.ex), .wb(wbBus.fwd),
		.exRd_o(exRd), .exIsLoad_o(exIsLoad), .exValid_o(exValid),
		.aluResult_o(aluResult), .storeData_o(storeData), .memRd_o(memRd),
		.memOp_o(memOp), .memWritesRd_o(memWritesRd), .memValid_o(memValid)
	);

	memStage memStage_i (
		.clk(clk), .reset(reset),
		.aluResult_i(aluResult), .storeData_i(storeData), .rd_i(memRd),
		.memOp_i(memOp), .writesRd_i(memWritesRd), .valid_i(memValid),
		.wb(wbBus.src),
		.retireValid_o(retireValid_o), .retireRd_o(retireRd_o), .retireData_o(retireData_o)
	);

endmodule

/* src/rv32CorePkg.sv */
package rv32CorePkg;

	localparam int XLEN = 32;
	localparam int REG_NUM_W = 5;
	localparam int IQ_DEPTH = 4;
	localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
	localparam int CREDIT_W = 3; // holds 0..IQ_DEPTH
	localparam int DMEM_WORDS = 1024;
	localparam int DMEM_AW = $clog2(DMEM_WORDS); // word index from addr[11:2]

	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_LUI = 7'b0110111;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS_Y // lui
	} aluOp_t;

	typedef enum logic [1:0] {
		NONE,
		LOAD,
		STORE
	} memOp_t;

	typedef struct packed {
		logic valid;
		aluOp_t aluOp;
		memOp_t memOp;
		logic [REG_NUM_W-1:0] rd;
		logic [REG_NUM_W-1:0] rs1;
		logic [REG_NUM_W-1:0] rs2;
		logic useImm;
		logic [XLEN-1:0] imm;
		logic writesRd;
	} decoded_t;

endpackage

/* tests/coreTb.sv */
`timescale 1ns/1ps

module coreTb;
	import rv32CorePkg::*;

	localparam int MAX_INSTR = 320;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic instrValid = 1'b0;
	logic [31:0] instr = '0;
	logic creditReturn;
	logic retireValid;
	logic [4:0] retireRd;
	logic [31:0] retireData;

	logic [31:0] prog [MAX_INSTR];
	logic [4:0] expRd [MAX_INSTR];
	logic [31:0] expData [MAX_INSTR];
	logic [31:0] refRegs [32];
	logic [31:0] refMem [16]; // x0-based addresses reach words 0..15 only
	int progLen = 0;
	int unsigned seed = 32'hbb9a;
	logic running = 1'b0;
	int credits = IQ_DEPTH;
	int sent = 0;
	int pulses = 0;
	int retired = 0;
	int checkErrors = 0;
	int rangeErrors = 0;
	int countErrors = 0;

	rv32Core rv32Core_i (
		.clk(clk), .reset(reset), .instrValid_i(instrValid), .instr_i(instr),
		.creditReturn_o(creditReturn), .retireValid_o(retireValid),
		.retireRd_o(retireRd), .retireData_o(retireData)
	);

	initial
	begin
		forever #5 clk = ~clk;
	end

	function automatic int unsigned nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed >> 12; // low LCG bits are weak
	endfunction

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, OP_LUI};
	endfunction

	// RV32I integer semantics by funct3
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// appends one instruction and steps the reference model
	task automatic emit(input logic [31:0] w);
		logic [6:0] op;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] val;
		op = w[6:0];
		rd = w[11:7];
		a = refRegs[w[19:15]];
		b = refRegs[w[24:20]];
		val = '0;
		case (op)
			OP_REG: val = refAlu(w[14:12], w[30], a, b);
			OP_IMM: val = refAlu(w[14:12], w[14:12] == 3'd5 && w[30], a, {{20{w[31]}}, w[31:20]});
			OP_LUI: val = {w[31:12], 12'b0};
			OP_LOAD:
			begin
				addr = a + {{20{w[31]}}, w[31:20]};
				val = refMem[addr[5:2]];
			end
			default:
			begin
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				refMem[addr[5:2]] = b;
				rd = '0; // stores retire without a destination
			end
		endcase
		if (rd == '0)
			val = '0;
		else
			refRegs[rd] = val;
		prog[progLen] = w;
		expRd[progLen] = rd;
		expData[progLen] = val;
		progLen++;
	endtask

	function automatic logic [31:0] randomInstr();
		int kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] shamt;
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm;
		logic [31:0] w;
		kind = int'(nextRand() % 10);
		rd = 5'(nextRand() % 8); // few registers give many dependencies
		rs1 = 5'(nextRand() % 8);
		rs2 = 5'(nextRand() % 8);
		shamt = 5'(nextRand());
		f3 = 3'(nextRand());
		alt = 1'(nextRand() % 2);
		imm = 12'(nextRand());
		if (kind < 3)
			w = encR((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd);
		else if (kind < 6)
		begin
			if (f3 == 3'd1)
				imm = {7'b0, shamt};
			else if (f3 == 3'd5)
				imm = {1'b0, alt, 5'b0, shamt};
			w = encI(imm, rs1, f3, rd, OP_IMM);
		end
		else if (kind == 6)
			w = encU(20'(nextRand()), rd);
		else if (kind < 9)
			w = encI(12'((nextRand() % 16) * 4), 5'd0, 3'd2, rd, OP_LOAD);
		else
			w = encS(12'((nextRand() % 16) * 4), rs2, 5'd0);
		return w;
	endfunction

	task automatic buildProgram();
		for (int k = 0; k < 32; k++)
			refRegs[k] = '0;
		for (int k = 1; k < 8; k++)
		begin
			emit(encU(20'(nextRand()), 5'(k)));
			emit(encI(12'(nextRand()), 5'(k), 3'd0, 5'(k), OP_IMM));
		end
		for (int k = 0; k < 16; k++)
			emit(encS(12'(k * 4), 5'(k % 8), 5'd0)); // every data word defined
		emit(encI(12'd5, 5'd0, 3'd0, 5'd1, OP_IMM));
		emit(encR(7'b0, 5'd1, 5'd1, 3'd0, 5'd2)); // forward from execute
		emit(encR(7'b0100000, 5'd1, 5'd2, 3'd0, 5'd3)); // execute and writeback
		emit(encR(7'b0, 5'd3, 5'd1, 3'd0, 5'd4));
		emit(encI(12'd7, 5'd1, 3'd0, 5'd0, OP_IMM));
		emit(encR(7'b0, 5'd0, 5'd0, 3'd0, 5'd5));
		emit(encI(12'hf85, 5'd0, 3'd0, 5'd6, OP_IMM));
		emit(encS(12'd8, 5'd6, 5'd0));
		emit(encS(12'd12, 5'd1, 5'd0));
		emit(encI(12'd8, 5'd0, 3'd2, 5'd7, OP_LOAD));
		emit(encR(7'b0, 5'd7, 5'd7, 3'd0, 5'd2)); // load-use
		emit(encI(12'd12, 5'd0, 3'd2, 5'd3, OP_LOAD));
		emit(encR(7'b0100000, 5'd7, 5'd3, 3'd0, 5'd4));
		// every pair stalls once, which drains the sender's credits
		for (int k = 0; k < 8; k++)
		begin
			emit(encI(12'(k * 4), 5'd0, 3'd2, 5'(k % 7 + 1), OP_LOAD));
			emit(encR(7'b0, 5'd1, 5'(k % 7 + 1), 3'd0, 5'(k % 7 + 1)));
		end
		for (int k = 0; k < 150; k++)
			emit(randomInstr());
	endtask

	// sender with credit accounting
	always @(negedge clk)
	begin
		if (creditReturn)
		begin
			credits++;
			pulses++;
		end
		if (running && sent < progLen && credits > 0)
		begin
			instr = prog[sent];
			instrValid = 1'b1;
			credits--;
			sent++;
		end
		else
			instrValid = 1'b0;
	end

	always @(negedge clk)
	begin
		if (!running)
		begin
			assert (!retireValid && !creditReturn)
				else begin
					checkErrors++;
					$display("ERROR %0t: activity with no input, retire %b credit %b",
						$time, retireValid, creditReturn);
				end
		end
		if (retireValid)
		begin
			assert (retired < progLen)
				else begin
					checkErrors++;
					$display("a retirement appeared with no instruction outstanding");
				end
		end
		if (retireValid && retired < progLen)
		begin
			assert (retireRd == expRd[retired] && retireData == expData[retired])
				else begin
					checkErrors++;
					$display("ERROR %0t: instr %0d (%h) retired x%0d=%h, expected x%0d=%h",
						$time, retired, prog[retired], retireRd, retireData,
						expRd[retired], expData[retired]);
				end
			retired++;
		end
	end

	creditRange: assert property (@(posedge clk) credits >= 0 && credits <= IQ_DEPTH)
		else begin
			rangeErrors++;
			$display("ERROR %0t: sender credit count %0d out of range", $time, credits);
		end

	initial
	begin
		wait (running);
		repeat (20 * progLen) @(posedge clk);
		$display("run timed out with %0d of %0d instructions retired", retired, progLen);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		int total;
		buildProgram();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		repeat (6) @(posedge clk); // idle window
		running = 1'b1;
		wait (retired == progLen);
		repeat (8) @(negedge clk);
		assert (pulses == sent && sent == progLen)
			else begin
				countErrors++;
				$display("ERROR %0t: credit pulses %0d, instructions sent %0d, program length %0d",
					$time, pulses, sent, progLen);
			end
		total = checkErrors + rangeErrors + countErrors;
		$display("errors: %0d retire, %0d credit range, %0d credit count (total %0d)",
			checkErrors, rangeErrors, countErrors, total);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
